/* flist.f */
rtl/rs_pkg.sv
rtl/rs_dispatch_if.sv
rtl/rs_issue_if.sv
rtl/rs_dispatch.sv
rtl/rs_entry_pool.sv
rtl/rs_issue_select.sv
rtl/rs_top.sv
tb/rs_assertions.sv
tb/rs_tb.sv

/* run.sh */
#!/bin/sh
# build the reservation station testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert --top-module rs_tb -f flist.f -o rs_sim \
	&& ./obj_dir/rs_sim | tee sim.log
grep -q "^TEST PASSED$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb/rs_tb.sv */
// reservation station testbench
// runs dispatch, CDB wakeup, bypass, back-pressure and flush scenarios
// against rs_top. a slot model predicts ack, rs_full and the FU ports
module rs_tb;
	import rs_pkg::*;

	localparam int RS_SIZE        = 8;
	localparam int DATA_W         = 64;
	localparam int TIMEOUT_CYCLES = 4000;   // about ten times the scenario length

	logic                          clock = 1'b0;
	logic                          rst_n;
	logic                          dispatch_req;
	tag_t                          dispatch_dest_tag;
	rob_idx_t                      dispatch_rob_idx;
	alu_func_t                     dispatch_alu_func;
	fu_sel_t                       dispatch_fu_sel;
	logic [DATA_W-1:0]             opa, opb;
	logic                          opa_valid, opb_valid, dispatch_ack;
	logic                          cdb_valid;
	tag_t                          cdb_tag;
	logic [DATA_W-1:0]             cdb_data;
	logic                          flush_thread1, flush_thread2, rs_full;
	logic [NUM_FU-1:0]             fu_available, issue_valid;
	rs_payload_t [NUM_FU-1:0]      issue_payload;
	logic [NUM_FU-1:0][DATA_W-1:0] issue_opa, issue_opb;

	// reference model with one record per slot
	logic [RS_SIZE-1:0] m_valid, m_a_rdy, m_b_rdy;
	rs_payload_t        m_pl [RS_SIZE];
	logic [DATA_W-1:0]  m_a [RS_SIZE];
	logic [DATA_W-1:0]  m_b [RS_SIZE];
	logic               m_ack;

	integer seed   = 65018;
	int     cycles = 0;

	rs_top #(.RS_SIZE(RS_SIZE), .DATA_W(DATA_W)) dut (.*);

	always #5 clock = ~clock;

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [63:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic fu_sel_t random_class();
		return fu_sel_t'(2'($unsigned($random(seed)) % 3));
	endfunction

	function automatic rob_idx_t random_rob();
		return rob_idx_t'($random(seed));
	endfunction

	// lowest-index ready entry of class c or -1 when the class cannot issue
	function automatic int expected_issue(input int c);
		int pick;
		pick = -1;
		for (int i = RS_SIZE - 1; i >= 0; i--) begin   // scan downward so the last hit is lowest
			if (fu_available[c] && m_valid[i] && m_a_rdy[i] && m_b_rdy[i] &&
			    int'(m_pl[i].fu_sel) == c)
				pick = i;
		end
		return pick;
	endfunction

	// full four-phase cycle with an optional CDB broadcast in the load cycle
	task automatic send(input rob_idx_t rob, input fu_sel_t fu,
	                    input logic a_vld, input logic [63:0] a,
	                    input logic b_vld, input logic [63:0] b,
	                    input logic bypass, input tag_t byp_tag);
		@(posedge clock);
		dispatch_req      <= 1'b1;
		dispatch_dest_tag <= tag_t'($random(seed));
		dispatch_rob_idx  <= rob;
		dispatch_alu_func <= alu_func_t'({1'b0, 3'($random(seed))});
		dispatch_fu_sel   <= fu;
		opa_valid         <= a_vld;
		opa               <= a;
		opb_valid         <= b_vld;
		opb               <= b;
		if (bypass) begin
			cdb_valid <= 1'b1;
			cdb_tag   <= byp_tag;
			cdb_data  <= random_word();
			@(posedge clock);
			cdb_valid <= 1'b0;                 // seen at the load edge only
		end
		do
			@(negedge clock);
		while (!dispatch_ack);
		@(posedge clock);
		dispatch_req <= 1'b0;
		do
			@(negedge clock);
		while (dispatch_ack);
	endtask

	task automatic send_ready(input rob_idx_t rob, input fu_sel_t fu);
		send(rob, fu, 1'b1, random_word(), 1'b1, random_word(), 1'b0, '0);
	endtask

	task automatic broadcast(input tag_t tag);
		@(posedge clock);
		cdb_valid <= 1'b1;
		cdb_tag   <= tag;
		cdb_data  <= random_word();
		@(posedge clock);
		cdb_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		do
			@(negedge clock);
		while (m_valid != '0);
	endtask

	//////////////////////////////
	// compare and model update
	//////////////////////////////

	always @(negedge clock) begin : compare_model
		logic [RS_SIZE-1:0] grant;
		logic               load;
		logic               placed;
		logic               a_hit;
		logic               b_hit;
		logic               flush;
		int                 k;
		if (!rst_n) begin
			m_valid <= '0;
			m_ack   <= 1'b0;
		end else begin
			check_value("dispatch_ack", 64'(dispatch_ack), 64'(m_ack));
			check_value("rs_full", 64'(rs_full), 64'(&m_valid));
			grant = '0;
			for (int c = 0; c < NUM_FU; c++) begin
				k = expected_issue(c);
				check_value($sformatf("issue_valid[%0d]", c), 64'(issue_valid[c]), 64'(k >= 0));
				if (k >= 0) begin
					grant[k] = 1'b1;
					check_value("issue_payload", 64'(issue_payload[c]), 64'(m_pl[k]));
					check_value("issue_opa", issue_opa[c], m_a[k]);
					check_value("issue_opb", issue_opb[c], m_b[k]);
				end
			end
			// state after the coming rising edge
			load   = dispatch_req && !m_ack && !(&m_valid);
			placed = 1'b0;
			a_hit  = !opa_valid && cdb_valid && opa[TAG_W-1:0] == cdb_tag;
			b_hit  = !opb_valid && cdb_valid && opb[TAG_W-1:0] == cdb_tag;
			for (int i = 0; i < RS_SIZE; i++) begin
				flush = m_pl[i].rob_idx[ROB_IDX_W-1] ? flush_thread2 : flush_thread1;
				if (load && !placed && !m_valid[i]) begin
					placed     = 1'b1;
					m_valid[i] <= 1'b1;
					m_pl[i]    <= '{dispatch_dest_tag, dispatch_rob_idx, dispatch_alu_func,
					                dispatch_fu_sel};
					m_a[i]     <= a_hit ? cdb_data : opa;
					m_a_rdy[i] <= opa_valid || a_hit;
					m_b[i]     <= b_hit ? cdb_data : opb;
					m_b_rdy[i] <= opb_valid || b_hit;
				end else if (m_valid[i]) begin
					if (grant[i] || flush)
						m_valid[i] <= 1'b0;
					if (!m_a_rdy[i] && cdb_valid && m_a[i][TAG_W-1:0] == cdb_tag) begin
						m_a[i]     <= cdb_data;
						m_a_rdy[i] <= 1'b1;
					end
					if (!m_b_rdy[i] && cdb_valid && m_b[i][TAG_W-1:0] == cdb_tag) begin
						m_b[i]     <= cdb_data;
						m_b_rdy[i] <= 1'b1;
					end
				end
			end
			if (load)
				m_ack <= 1'b1;
			else if (m_ack && !dispatch_req)
				m_ack <= 1'b0;
		end
	end

	always @(posedge clock) begin : watchdog
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// scenarios
	//////////////////////////////

	initial begin : stimulus
		rst_n             = 1'b0;
		dispatch_req      = 1'b0;
		dispatch_dest_tag = '0;
		dispatch_rob_idx  = '0;
		dispatch_alu_func = alu_add;
		dispatch_fu_sel   = use_mult;
		opa               = '0;
		opb               = '0;
		opa_valid         = 1'b0;
		opb_valid         = 1'b0;
		cdb_valid         = 1'b0;
		cdb_tag           = '0;
		cdb_data          = '0;
		flush_thread1     = 1'b0;
		flush_thread2     = 1'b0;
		fu_available      = '0;
		repeat (4) @(posedge clock);
		rst_n        <= 1'b1;
		fu_available <= '1;

		// operands present so each issues right after ack
		repeat (6)
			send_ready(random_rob(), random_class());
		wait_drain();

		// operands waiting on tags 5 and 9
		send(random_rob(), use_adder, 1'b0, 64'd5, 1'b1, random_word(), 1'b0, '0);
		send(random_rob(), use_mult, 1'b0, 64'd9, 1'b0, 64'd5, 1'b0, '0);
		repeat (3) @(posedge clock);
		broadcast(6'd5);
		repeat (2) @(posedge clock);
		broadcast(6'd9);
		wait_drain();

		// broadcast lands in the load cycle
		send(random_rob(), use_memory, 1'b0, 64'd12, 1'b1, random_word(), 1'b1, 6'd12);
		send(random_rob(), use_adder, 1'b0, 64'd20, 1'b0, 64'd20, 1'b1, 6'd20);
		wait_drain();

		// fill the pool with all units busy and let a ninth wait for a free slot
		@(posedge clock);
		fu_available <= '0;
		repeat (RS_SIZE)
			send_ready(random_rob(), random_class());
		check_value("rs_full", 64'(rs_full), 64'd1);
		fork
			send_ready(random_rob(), random_class());
			begin
				repeat (8) @(posedge clock);
				fu_available <= '1;
			end
		join
		wait_drain();

		// flush thread 1 with both threads waiting and refill the freed slots
		@(posedge clock);
		fu_available <= '0;
		for (int i = 0; i < RS_SIZE; i++)
			send_ready({i[0], 4'($random(seed))}, random_class());
		@(posedge clock);
		flush_thread1 <= 1'b1;
		@(posedge clock);
		flush_thread1 <= 1'b0;
		repeat (4)
			send_ready(random_rob(), random_class());
		@(posedge clock);
		fu_available <= '1;
		wait_drain();

		repeat (2) @(posedge clock);
		if (dut.u_assertions.failures == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

/* tb/rs_assertions.sv */
// reservation station protocol assertions
// four-phase dispatch handshake and FU port gating, bound into rs_top
module rs_assertions (
	input logic                      clock,
	input logic                      rst_n,
	input logic                      dispatch_req,
	input logic                      dispatch_ack,
	input logic [rs_pkg::NUM_FU-1:0] fu_available,
	input logic [rs_pkg::NUM_FU-1:0] issue_valid
);

	int failures = 0;   // failed assertions so far

	// ack rises only at an edge where req is high
	ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(dispatch_ack) |-> $past(dispatch_req))
		else begin
			failures++;
			$error("dispatch_ack rose while dispatch_req was low");
		end

	ack_falls_after_req: assert property (@(posedge clock) disable iff (!rst_n)
		$fell(dispatch_ack) |-> !$past(dispatch_req))
		else begin
			failures++;
			$error("dispatch_ack fell while dispatch_req was still high");
		end

	// a busy unit never sees an issue
	issue_gated: assert property (@(posedge clock) disable iff (!rst_n)
		(issue_valid & ~fu_available) == '0)
		else begin
			failures++;
			$error("issue_valid high on a port whose FU is not available");
		end

endmodule

bind rs_top rs_assertions u_assertions (.*);

/* rtl/rs_top.sv */
// reservation station top level
// single dispatch port with four-phase handshake, one CDB, per-thread
// flush and three FU class ports. wires the dispatch stage, the entry
// pool and the issue selector together
module rs_top #(
	parameter int RS_SIZE = 8,
	parameter int DATA_W  = 64
) (
	input  logic                                  clock,
	input  logic                                  rst_n,

	// dispatch from rename
	input  logic                                  dispatch_req,
	input  rs_pkg::tag_t                          dispatch_dest_tag,
	input  rs_pkg::rob_idx_t                      dispatch_rob_idx,
	input  rs_pkg::alu_func_t                     dispatch_alu_func,
	input  rs_pkg::fu_sel_t                       dispatch_fu_sel,
	input  logic [DATA_W-1:0]                     opa,
	input  logic                                  opa_valid,
	input  logic [DATA_W-1:0]                     opb,
	input  logic                                  opb_valid,
	output logic                                  dispatch_ack,

	// common data bus
	input  logic                                  cdb_valid,
	input  rs_pkg::tag_t                          cdb_tag,
	input  logic [DATA_W-1:0]                     cdb_data,

	input  logic                                  flush_thread1,
	input  logic                                  flush_thread2,

	// FU class ports, index is fu_sel_t
	input  logic [rs_pkg::NUM_FU-1:0]             fu_available,
	output logic [rs_pkg::NUM_FU-1:0]             issue_valid,
	output rs_pkg::rs_payload_t [rs_pkg::NUM_FU-1:0] issue_payload,
	output logic [rs_pkg::NUM_FU-1:0][DATA_W-1:0] issue_opa,
	output logic [rs_pkg::NUM_FU-1:0][DATA_W-1:0] issue_opb,

	output logic                                  rs_full
);
	import rs_pkg::*;

	rs_payload_t dispatch_payload;

	assign dispatch_payload = '{
		dest_tag: dispatch_dest_tag,
		rob_idx:  dispatch_rob_idx,
		alu_func: dispatch_alu_func,
		fu_sel:   dispatch_fu_sel
	};

	rs_dispatch_if #(.RS_SIZE(RS_SIZE), .DATA_W(DATA_W)) dsp_if ();
	rs_issue_if    #(.RS_SIZE(RS_SIZE), .DATA_W(DATA_W)) iss_if ();

	rs_dispatch #(.DATA_W(DATA_W)) u_dispatch (
		.clock        (clock),
		.rst_n        (rst_n),
		.dispatch_req (dispatch_req),
		.payload      (dispatch_payload),
		.opa          (opa),
		.opb          (opb),
		.opa_valid    (opa_valid),
		.opb_valid    (opb_valid),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.dispatch_ack (dispatch_ack),
		.dsp          (dsp_if.dispatch)
	);

	rs_entry_pool #(.RS_SIZE(RS_SIZE), .DATA_W(DATA_W)) u_pool (
		.clock         (clock),
		.rst_n         (rst_n),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_data      (cdb_data),
		.flush_thread1 (flush_thread1),
		.flush_thread2 (flush_thread2),
		.rs_full       (rs_full),
		.dsp           (dsp_if.pool),
		.iss           (iss_if.pool)
	);

	rs_issue_select #(.RS_SIZE(RS_SIZE), .DATA_W(DATA_W)) u_select (
		.fu_available  (fu_available),
		.issue_valid   (issue_valid),
		.issue_payload (issue_payload),
		.issue_opa     (issue_opa),
		.issue_opb     (issue_opb),
		.iss           (iss_if.select)
	);

endmodule

/* rtl/rs_issue_select.sv */
// reservation station issue selector
// one port per FU class (multiplier, adder, memory). each available
// class takes the lowest-index ready entry of its own class and grants
// it back to the pool. an entry belongs to one class only, so a grant
// vector never carries two bits for the same entry
module rs_issue_select #(
	parameter int RS_SIZE = 8,
	parameter int DATA_W  = 64
) (
	input  logic [rs_pkg::NUM_FU-1:0]              fu_available,
	output logic [rs_pkg::NUM_FU-1:0]              issue_valid,
	output rs_pkg::rs_payload_t [rs_pkg::NUM_FU-1:0] issue_payload,
	output logic [rs_pkg::NUM_FU-1:0][DATA_W-1:0]  issue_opa,
	output logic [rs_pkg::NUM_FU-1:0][DATA_W-1:0]  issue_opb,
	rs_issue_if.select                             iss
);
	import rs_pkg::*;

	//////////////////////////////
	// per-class pick
	//////////////////////////////

	always_comb begin
		issue_valid   = '0;
		issue_payload = '0;
		issue_opa     = '0;
		issue_opb     = '0;
		iss.grant     = '0;

		for (int c = 0; c < NUM_FU; c++) begin
			for (int i = 0; i < RS_SIZE; i++) begin
				// first hit wins, issue_valid blocks the rest of the scan
				if (fu_available[c] && !issue_valid[c] && iss.ready[i] &&
				    (iss.payload[i].fu_sel == fu_sel_t'(FU_SEL_W'(c)))) begin
					issue_valid[c]   = 1'b1;
					issue_payload[c] = iss.payload[i];
					issue_opa[c]     = iss.opa[i];
					issue_opb[c]     = iss.opb[i];
					iss.grant[i]     = 1'b1;   // frees the entry at the next edge
				end
			end
		end
	end

endmodule

/* rtl/rs_entry_pool.sv */
// reservation station entry pool
// RS_SIZE slots, each holding a payload and two operands with their
// ready flags. a load goes to the lowest free slot, waiting operands
// snoop the CDB every cycle, and an entry leaves on grant or when its
// thread is flushed
module rs_entry_pool #(
	parameter int RS_SIZE = 8,
	parameter int DATA_W  = 64
) (
	input  logic              clock,
	input  logic              rst_n,

	input  logic              cdb_valid,
	input  rs_pkg::tag_t      cdb_tag,
	input  logic [DATA_W-1:0] cdb_data,

	input  logic              flush_thread1,
	input  logic              flush_thread2,

	output logic              rs_full,
	rs_dispatch_if.pool       dsp,
	rs_issue_if.pool          iss
);
	import rs_pkg::*;

	logic [RS_SIZE-1:0]             valid;
	logic [RS_SIZE-1:0]             opa_rdy;
	logic [RS_SIZE-1:0]             opb_rdy;
	rs_payload_t [RS_SIZE-1:0]      payload;
	logic [RS_SIZE-1:0][DATA_W-1:0] opa;       // value, or tag while not ready
	logic [RS_SIZE-1:0][DATA_W-1:0] opb;

	logic [RS_SIZE-1:0]             load_sel;  // one-hot target of this load
	logic [RS_SIZE-1:0]             wake_a;
	logic [RS_SIZE-1:0]             wake_b;
	logic [RS_SIZE-1:0]             flush_hit;

	//////////////////////////////
	// allocation
	//////////////////////////////

	always_comb begin
		logic found;
		found    = 1'b0;
		load_sel = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (!valid[i] && !found) begin
				load_sel[i] = dsp.load;
				found       = 1'b1;
			end
		end
	end

	//////////////////////////////
	// wakeup and flush
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			wake_a[i] = valid[i] && !opa_rdy[i] && cdb_valid &&
			            (opa[i][TAG_W-1:0] == cdb_tag);
			wake_b[i] = valid[i] && !opb_rdy[i] && cdb_valid &&
			            (opb[i][TAG_W-1:0] == cdb_tag);
			// thread bit 0 is thread 1
			flush_hit[i] = valid[i] &&
			               (payload[i].rob_idx[ROB_IDX_W-1] ? flush_thread2 : flush_thread1);
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid   <= '0;
			opa_rdy <= '0;
			opb_rdy <= '0;
		end else begin
			for (int i = 0; i < RS_SIZE; i++) begin
				if (load_sel[i]) begin
					valid[i]   <= 1'b1;      // a new load survives a flush
					opa_rdy[i] <= dsp.opa_valid;
					opb_rdy[i] <= dsp.opb_valid;
				end else begin
					if (iss.grant[i] || flush_hit[i])
						valid[i] <= 1'b0;
					if (wake_a[i])
						opa_rdy[i] <= 1'b1;
					if (wake_b[i])
						opb_rdy[i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_SIZE; i++) begin
			if (load_sel[i]) begin
				payload[i] <= dsp.payload;
				opa[i]     <= dsp.opa;
				opb[i]     <= dsp.opb;
			end else begin
				if (wake_a[i])
					opa[i] <= cdb_data;     // broadcast value replaces the tag
				if (wake_b[i])
					opb[i] <= cdb_data;
			end
		end
	end

	assign dsp.free_slots = ~valid;
	assign rs_full        = !dsp.can_load;

	assign iss.ready   = valid & opa_rdy & opb_rdy;
	assign iss.payload = payload;
	assign iss.opa     = opa;
	assign iss.opb     = opb;

endmodule

/* rtl/rs_dispatch.sv */
// reservation station dispatch stage
// runs the four-phase req/ack handshake with rename and turns an
// accepted request into a one-cycle load toward the entry pool.
// an operand still waiting on a tag is replaced by CDB data when the
// broadcast in the load cycle carries that tag
module rs_dispatch #(
	parameter int DATA_W = 64
) (
	input  logic                clock,
	input  logic                rst_n,

	input  logic                dispatch_req,
	input  rs_pkg::rs_payload_t payload,
	input  logic [DATA_W-1:0]   opa,
	input  logic [DATA_W-1:0]   opb,
	input  logic                opa_valid,
	input  logic                opb_valid,

	input  logic                cdb_valid,
	input  rs_pkg::tag_t        cdb_tag,
	input  logic [DATA_W-1:0]   cdb_data,

	output logic                dispatch_ack,
	rs_dispatch_if.dispatch     dsp
);
	import rs_pkg::*;

	logic accept;      // request seen, ack not yet given, slot free
	logic opa_hit;
	logic opb_hit;

	//////////////////////////////
	// handshake
	//////////////////////////////

	assign accept = dispatch_req && !dispatch_ack && dsp.can_load;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dispatch_ack <= 1'b0;
		end else if (accept) begin
			dispatch_ack <= 1'b1;            // entry written at this same edge
		end else if (dispatch_ack && !dispatch_req) begin
			dispatch_ack <= 1'b0;            // req dropped, close the cycle
		end
	end

	assign dsp.load    = accept;
	assign dsp.payload = payload;

	//////////////////////////////
	// CDB bypass
	//////////////////////////////

	// the tag sits in the low bits while an operand is not valid
	assign opa_hit = !opa_valid && cdb_valid && (opa[TAG_W-1:0] == cdb_tag);
	assign opb_hit = !opb_valid && cdb_valid && (opb[TAG_W-1:0] == cdb_tag);

	always_comb begin
		dsp.opa       = opa;
		dsp.opa_valid = opa_valid;
		dsp.opb       = opb;
		dsp.opb_valid = opb_valid;

		if (opa_hit) begin
			dsp.opa       = cdb_data;
			dsp.opa_valid = 1'b1;
		end
		if (opb_hit) begin
			dsp.opb       = cdb_data;
			dsp.opb_valid = 1'b1;
		end
	end

endmodule

/* rtl/rs_issue_if.sv */
// entry pool to issue selector link
// per-entry ready flags and contents go to the selector,
// grant comes back and frees the chosen entries at the next edge
interface rs_issue_if #(
	parameter int RS_SIZE = 8,
	parameter int DATA_W  = 64
);
	import rs_pkg::*;

	logic [RS_SIZE-1:0]             ready;     // valid with both operands present
	rs_payload_t [RS_SIZE-1:0]      payload;
	logic [RS_SIZE-1:0][DATA_W-1:0] opa;
	logic [RS_SIZE-1:0][DATA_W-1:0] opb;
	logic [RS_SIZE-1:0]             grant;     // at most one bit per FU class

	modport pool (
		output ready, payload, opa, opb,
		input  grant
	);

	modport select (
		input  ready, payload, opa, opb,
		output grant
	);

endinterface

/* rtl/rs_dispatch_if.sv */
// dispatch to entry pool link
// carries one instruction per load pulse, operands already bypassed,
// and returns the free slot vector of the pool
interface rs_dispatch_if #(
	parameter int RS_SIZE = 8,
	parameter int DATA_W  = 64
);
	import rs_pkg::*;

	logic               load;         // one-cycle pulse the pool always takes
	rs_payload_t        payload;
	logic [DATA_W-1:0]  opa;
	logic               opa_valid;    // opa low bits hold the tag while low
	logic [DATA_W-1:0]  opb;
	logic               opb_valid;
	logic [RS_SIZE-1:0] free_slots;   // one bit per empty entry
	logic               can_load;

	assign can_load = |free_slots;

	modport dispatch (
		output load, payload, opa, opa_valid, opb, opb_valid,
		input  can_load
	);

	modport pool (
		input  load, payload, opa, opa_valid, opb, opb_valid, can_load,
		output free_slots
	);

endinterface

/* rtl/rs_pkg.sv */
// reservation station shared definitions
// physical register and ROB sizing, ALU function and FU class encodings,
// and the payload that each entry carries from dispatch to issue
package rs_pkg;

	localparam int PRF_SIZE  = 64;
	localparam int ROB_SIZE  = 16;                     // entries per thread
	localparam int NUM_FU    = 3;                      // one issue port per FU class
	localparam int TAG_W     = $clog2(PRF_SIZE);
	localparam int ROB_IDX_W = $clog2(ROB_SIZE) + 1;   // top bit picks the thread
	localparam int FU_SEL_W  = 2;

	typedef logic [TAG_W-1:0]     tag_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	// ALU operations decoded upstream
	typedef enum logic [3:0] {
		alu_add     = 4'h0,
		alu_sub     = 4'h1,
		alu_and     = 4'h2,
		alu_or      = 4'h3,
		alu_xor     = 4'h4,
		alu_sll     = 4'h5,
		alu_srl     = 4'h6,
		alu_sra     = 4'h7,
		alu_mulq    = 4'h8,
		alu_cmpeq   = 4'h9,
		alu_cmplt   = 4'ha,
		alu_cmple   = 4'hb,
		alu_default = 4'hf
	} alu_func_t;

	// value doubles as the FU port index
	typedef enum logic [FU_SEL_W-1:0] {
		use_mult   = 2'd0,
		use_adder  = 2'd1,
		use_memory = 2'd2
	} fu_sel_t;

	typedef struct packed {
		tag_t      dest_tag;
		rob_idx_t  rob_idx;
		alu_func_t alu_func;
		fu_sel_t   fu_sel;
	} rs_payload_t;

endpackage
